/* design/prbs_pkg.sv */
`default_nettype none

package prbs_pkg;

    // checker modes
    localparam logic [1:0] mode_reset  = 2'd0;
    localparam logic [1:0] mode_align  = 2'd1;
    localparam logic [1:0] mode_test   = 2'd2;
    localparam logic [1:0] mode_freeze = 2'd3;

    // host write addresses
    localparam logic [1:0] addr_ctrl   = 2'd0;
    localparam logic [1:0] addr_eqn    = 2'd1;
    localparam logic [1:0] addr_inject = 2'd2;

    // host write data width
    localparam int reg_width = 32;

    // control word fields, msb first, so mode sits in bits 1:0
    typedef struct packed {
        logic [9:0]  reserved;
        logic [15:0] chan_sel;
        logic        run;
        logic        tx_invert;
        logic [1:0]  inv_chicken;
        logic [1:0]  mode;
    } ctrl_fields_t;

    // raw view for equation and mask writes, field view for control writes
    typedef union packed {
        logic [reg_width-1:0] raw;
        ctrl_fields_t         fields;
    } ctrl_word_t;

endpackage

`default_nettype wire

/* design/prbs_ctrl_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module prbs_ctrl_regs #(
    parameter int n_channels = 16
) (
    input  wire logic                             clk,
    input  wire logic                             reset,

    // host write port
    input  wire logic                             wr_strobe,
    input  wire logic [1:0]                       wr_addr,
    input  wire logic [prbs_pkg::reg_width-1:0]   wr_data,

    // checker controls
    output logic [1:0]                            checker_mode,
    output logic [1:0]                            inv_chicken,
    output logic [n_channels-1:0]                 chan_sel,

    // generator controls
    output logic                                  tx_invert,
    output logic                                  run,
    output logic [n_channels-1:0]                 inject,

    // shared equation taps
    output logic [prbs_pkg::reg_width-1:0]        eqn
);

    prbs_pkg::ctrl_word_t wr_word;

    logic wr_ctrl;
    logic wr_eqn;
    logic wr_inject;

    // every write is seen through the union
    assign wr_word.raw = wr_data;

    assign wr_ctrl   = wr_strobe && (wr_addr == prbs_pkg::addr_ctrl);
    assign wr_eqn    = wr_strobe && (wr_addr == prbs_pkg::addr_eqn);
    assign wr_inject = wr_strobe && (wr_addr == prbs_pkg::addr_inject);

    // control word fields
    always_ff @(posedge clk) begin
        if (reset) begin
            checker_mode <= prbs_pkg::mode_reset;
            inv_chicken  <= 2'b00;
            tx_invert    <= 1'b0;
            run          <= 1'b0;
            chan_sel     <= '0;
        end else if (wr_ctrl) begin
            checker_mode <= wr_word.fields.mode;
            inv_chicken  <= wr_word.fields.inv_chicken;
            tx_invert    <= wr_word.fields.tx_invert;
            run          <= wr_word.fields.run;
            chan_sel     <= wr_word.fields.chan_sel[n_channels-1:0];
        end
    end

    // equation taps, raw view
    always_ff @(posedge clk) begin
        if (reset) begin
            eqn <= '0;
        end else if (wr_eqn) begin
            eqn <= wr_word.raw;
        end
    end

    // injection mask lives for exactly one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            inject <= '0;
        end else if (wr_inject) begin
            inject <= wr_word.raw[n_channels-1:0];
        end else begin
            inject <= '0;
        end
    end

endmodule

`default_nettype wire

/* design/prbs_generator.sv */
`timescale 1ns/100ps
`default_nettype none

module prbs_generator #(
    parameter int n_prbs     = 32,
    parameter int n_channels = 16
) (
    input  wire logic                  clk,
    input  wire logic                  reset,

    // advance enable
    input  wire logic                  run,

    // shared taps
    input  wire logic [n_prbs-1:0]     eqn,

    // line controls
    input  wire logic                  tx_invert,
    input  wire logic [n_channels-1:0] inject,

    // one registered bit per lane
    output logic [n_channels-1:0]      tx_bits
);

    genvar k;
    generate
        for (k = 0; k < n_channels; k = k + 1) begin : g_lane
            logic [n_prbs-1:0] lfsr;
            logic              next_bit;

            // fibonacci feedback from the tapped state bits
            assign next_bit = ^(lfsr & eqn);

            always_ff @(posedge clk) begin
                if (reset) begin
                    // distinct nonzero seed per lane
                    lfsr       <= n_prbs'(k + 1);
                    tx_bits[k] <= 1'b0;
                end else if (run) begin
                    lfsr       <= {lfsr[n_prbs-2:0], next_bit};
                    // flips only the line bit, the lfsr stays clean
                    tx_bits[k] <= next_bit ^ tx_invert ^ inject[k];
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* design/prbs_checker_core.sv */
`timescale 1ns/100ps
`default_nettype none

module prbs_checker_core #(
    parameter int n_prbs = 32
) (
    input  wire logic              clk,
    input  wire logic              reset,

    // advance enable
    input  wire logic              cke,

    // taps, same meaning as in the generator
    input  wire logic [n_prbs-1:0] eqn,

    // bit 0 flips the received bit, bit 1 flips err
    input  wire logic [1:0]        inv_chicken,

    // received line bit
    input  wire logic              rx_bit,

    // registered mismatch flag
    output logic                   err
);

    // last n_prbs received bits, newest in bit 0
    logic [n_prbs-1:0] history;

    logic rx_corr;
    logic predicted;
    logic mismatch;

    // undo a transmit inversion if asked to
    assign rx_corr = rx_bit ^ inv_chicken[0];

    // the next bit the stream should carry, from what was seen so far
    assign predicted = ^(history & eqn);

    /*
     * The prediction only holds once the history is filled with n_prbs
     * bits of the current stream. Before that err is meaningless, which
     * is what align mode in the checker is there to ride out. A single
     * flipped bit shows up once as itself and once more for each tap
     * while it walks through the history.
     */
    assign mismatch = rx_corr ^ predicted ^ inv_chicken[1];

    // history follows the received stream, errors and all
    always_ff @(posedge clk) begin
        if (reset) begin
            history <= '0;
        end else if (cke) begin
            history <= {history[n_prbs-2:0], rx_corr};
        end
    end

    // err lands one cycle after its rx bit
    always_ff @(posedge clk) begin
        if (reset) begin
            err <= 1'b0;
        end else if (cke) begin
            err <= mismatch;
        end
    end

endmodule

`default_nettype wire

/* design/prbs_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module prbs_checker #(
    parameter int n_prbs     = 32,
    parameter int n_channels = 16
) (
    input  wire logic                  clk,
    input  wire logic                  reset,

    // advance enable
    input  wire logic                  cke,

    // prbs taps
    input  wire logic [n_prbs-1:0]     eqn,

    // lanes that take part in the counts
    input  wire logic [n_channels-1:0] chan_sel,

    // inversion bits
    input  wire logic [1:0]            inv_chicken,

    // received lanes
    input  wire logic [n_channels-1:0] rx_bits,

    // reset, align, test or freeze
    input  wire logic [1:0]            checker_mode,

    output logic [63:0]                err_bits,
    output logic [63:0]                total_bits,
    output logic                       error_in_frame
);

    // wide enough for a full count of n_channels
    localparam int cnt_w = $clog2(n_channels) + 1;

    logic [n_channels-1:0] err_flags;
    logic [cnt_w-1:0]      err_count;
    logic [cnt_w-1:0]      tot_count;

    // one predictor per lane
    genvar k;
    generate
        for (k = 0; k < n_channels; k = k + 1) begin : g_core
            prbs_checker_core #(
                .n_prbs(n_prbs)
            ) u_core (
                .clk        (clk),
                .reset      (reset),
                .cke        (cke),
                .eqn        (eqn),
                .inv_chicken(inv_chicken),
                .rx_bit     (rx_bits[k]),
                .err        (err_flags[k])
            );
        end
    endgenerate

    // per-cycle sums over the selected lanes
    always_comb begin
        err_count = '0;
        tot_count = '0;
        for (int i = 0; i < n_channels; i = i + 1) begin
            err_count = err_count + cnt_w'(err_flags[i] & chan_sel[i]);
            tot_count = tot_count + cnt_w'(chan_sel[i]);
        end
    end

    // mode-controlled counters
    always_ff @(posedge clk) begin
        if (reset) begin
            err_bits   <= '0;
            total_bits <= '0;
        end else begin
            case (checker_mode)
                prbs_pkg::mode_reset: begin
                    err_bits   <= '0;
                    total_bits <= '0;
                end
                prbs_pkg::mode_test: begin
                    if (cke) begin
                        err_bits   <= err_bits + 64'(err_count);
                        total_bits <= total_bits + 64'(tot_count);
                    end
                end
                // align and freeze hold
                default: begin
                    err_bits   <= err_bits;
                    total_bits <= total_bits;
                end
            endcase
        end
    end

    // any lane at all, selected or not
    always_ff @(posedge clk) begin
        if (reset) begin
            error_in_frame <= 1'b0;
        end else begin
            error_in_frame <= |err_flags;
        end
    end

endmodule

`default_nettype wire

/* design/prbs_loopback_top.sv */
`timescale 1ns/100ps
`default_nettype none

module prbs_loopback_top #(
    parameter int n_prbs     = 32,
    parameter int n_channels = 16
) (
    input  wire logic                           clk,
    input  wire logic                           reset,

    // host write port
    input  wire logic                           wr_strobe,
    input  wire logic [1:0]                     wr_addr,
    input  wire logic [prbs_pkg::reg_width-1:0] wr_data,

    // test results
    output logic [63:0]                         err_bits,
    output logic [63:0]                         total_bits,
    output logic                                error_in_frame
);

    logic [1:0]                     checker_mode;
    logic [1:0]                     inv_chicken;
    logic [n_channels-1:0]          chan_sel;
    logic                           tx_invert;
    logic                           run;
    logic [n_channels-1:0]          inject;
    logic [prbs_pkg::reg_width-1:0] eqn;
    logic [n_channels-1:0]          tx_bits;

    prbs_ctrl_regs #(
        .n_channels(n_channels)
    ) u_regs (
        .clk         (clk),
        .reset       (reset),
        .wr_strobe   (wr_strobe),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .checker_mode(checker_mode),
        .inv_chicken (inv_chicken),
        .chan_sel    (chan_sel),
        .tx_invert   (tx_invert),
        .run         (run),
        .inject      (inject),
        .eqn         (eqn)
    );

    // stands in for the analog front end
    prbs_generator #(
        .n_prbs    (n_prbs),
        .n_channels(n_channels)
    ) u_gen (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .eqn      (eqn[n_prbs-1:0]),
        .tx_invert(tx_invert),
        .inject   (inject),
        .tx_bits  (tx_bits)
    );

    // loopback, tx lanes straight into rx
    prbs_checker #(
        .n_prbs    (n_prbs),
        .n_channels(n_channels)
    ) u_chk (
        .clk           (clk),
        .reset         (reset),
        .cke           (run),
        .eqn           (eqn[n_prbs-1:0]),
        .chan_sel      (chan_sel),
        .inv_chicken   (inv_chicken),
        .rx_bits       (tx_bits),
        .checker_mode  (checker_mode),
        .err_bits      (err_bits),
        .total_bits    (total_bits),
        .error_in_frame(error_in_frame)
    );

endmodule

`default_nettype wire

/* dv/prbs_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module prbs_clk_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset held for the first 4 rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* dv/prbs_checker_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module prbs_checker_checker (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        wr_strobe,
    input wire logic [1:0]  wr_addr,
    input wire logic [31:0] wr_data,
    input wire logic [1:0]  checker_mode,
    input wire logic        run,
    input wire logic [15:0] chan_sel,
    input wire logic [63:0] err_bits,
    input wire logic [63:0] total_bits,
    input wire logic        error_in_frame
);

    // mode field sits in the low bits of a control word
    a_reset_write: assert property (@(posedge clk) disable iff (reset)
        $past(wr_strobe && wr_addr == prbs_pkg::addr_ctrl
              && wr_data[1:0] == prbs_pkg::mode_reset)
        |=> (err_bits == 64'd0 && total_bits == 64'd0))
        else $error("counters not cleared after a reset mode write");

    // total grows by the selected lane count each test cycle
    a_total_step: assert property (@(posedge clk) disable iff (reset)
        (checker_mode == prbs_pkg::mode_test && run)
        |=> (total_bits == $past(total_bits) + 64'($countones($past(chan_sel)))))
        else $error("total_bits step differs from lane count");

    // a counted error always shows in the frame flag as well
    a_err_frame: assert property (@(posedge clk) disable iff (reset)
        (err_bits > $past(err_bits)) |-> error_in_frame)
        else $error("err_bits grew while error_in_frame was low");

    // align and freeze hold both counters
    a_hold: assert property (@(posedge clk) disable iff (reset)
        (checker_mode == prbs_pkg::mode_align || checker_mode == prbs_pkg::mode_freeze)
        |=> ($stable(err_bits) && $stable(total_bits)))
        else $error("counters moved while holding");

    // reset mode clears on the following edge
    a_clear: assert property (@(posedge clk) disable iff (reset)
        (checker_mode == prbs_pkg::mode_reset)
        |=> (err_bits == 64'd0 && total_bits == 64'd0))
        else $error("counters not cleared in reset mode");

    // out of reset everything starts at zero
    a_after_reset: assert property (@(posedge clk)
        reset |=> (err_bits == 64'd0 && total_bits == 64'd0 && !error_in_frame))
        else $error("outputs not zero after reset");

endmodule

bind prbs_loopback_top prbs_checker_checker u_checker (
    .clk           (clk),
    .reset         (reset),
    .wr_strobe     (wr_strobe),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .checker_mode  (checker_mode),
    .run           (run),
    .chan_sel      (chan_sel),
    .err_bits      (err_bits),
    .total_bits    (total_bits),
    .error_in_frame(error_in_frame)
);

`default_nettype wire

/* dv/prbs_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module prbs_tb;

    localparam int timeout_cycles = 3000;
    // x^31 + x^28 + 1 has two taps so a flipped bit is seen three times
    localparam logic [31:0] eqn_taps = 32'h4800_0000;

    logic        clk;
    logic        reset;
    logic        wr_strobe;
    logic [1:0]  wr_addr;
    logic [31:0] wr_data;
    logic [63:0] err_bits;
    logic [63:0] total_bits;
    logic        error_in_frame;

    integer      seed = 32'hdba4_1712;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic        frame_seen = 1'b0;
    logic [63:0] base_err;
    logic [63:0] base_tot;
    logic [15:0] sel;
    logic [15:0] mask;

    prbs_clk_gen u_clk (
        .clk  (clk),
        .reset(reset)
    );

    prbs_loopback_top u_dut (
        .clk           (clk),
        .reset         (reset),
        .wr_strobe     (wr_strobe),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .err_bits      (err_bits),
        .total_bits    (total_bits),
        .error_in_frame(error_in_frame)
    );

    function automatic logic [31:0] ctrl_word(input logic [1:0] mode, input logic [1:0] inv,
                                              input logic txinv, input logic [15:0] lanes);
        prbs_pkg::ctrl_word_t w;
        w.raw                = '0;
        w.fields.mode        = mode;
        w.fields.inv_chicken = inv;
        w.fields.tx_invert   = txinv;
        w.fields.run         = 1'b1;
        w.fields.chan_sel    = lanes;
        return w.raw;
    endfunction

    function automatic int ones(input logic [15:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 16; i++) begin
            n += v[i];
        end
        return n;
    endfunction

    // single-cycle strobe that lands on the following edge
    task automatic host_write(input logic [1:0] addr, input logic [31:0] data);
        @(posedge clk);
        wr_strobe <= 1'b1;
        wr_addr   <= addr;
        wr_data   <= data;
        @(posedge clk);
        wr_strobe <= 1'b0;
    endtask

    task automatic snapshot();
        @(negedge clk);
        base_err   = err_bits;
        base_tot   = total_bits;
        frame_seen = 1'b0;
    endtask

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (exp == act) else begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // run n edges then compare deltas at the falling edge
    task automatic expect_deltas(input int n, input logic [63:0] d_err, input logic [63:0] d_tot);
        repeat (n) @(posedge clk);
        @(negedge clk);
        compare("err_bits", base_err + d_err, err_bits);
        compare("total_bits", base_tot + d_tot, total_bits);
    endtask

    task automatic expect_frame(input logic exp);
        checks++;
        assert (frame_seen == exp) else begin
            $display("error_in_frame was %s during the burst", exp ? "never high" : "high");
            errors++;
        end
    endtask

    // frame flag as it stood over the cycle that just ended
    always @(posedge clk) begin
        if (error_in_frame) begin
            frame_seen = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("run did not finish within %0d cycles", timeout_cycles);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        wr_strobe <= 1'b0;
        wr_addr   <= 2'd0;
        wr_data   <= 32'd0;
        sel = 16'($random(seed)) | 16'h0001;
        @(negedge reset);
        // counts start from zero out of reset
        base_err   = 64'd0;
        base_tot   = 64'd0;
        frame_seen = 1'b0;
        expect_deltas(20, 64'd0, 64'd0);
        expect_frame(1'b0);

        // bring up, align, then a clean test run
        host_write(prbs_pkg::addr_eqn, eqn_taps);
        host_write(prbs_pkg::addr_ctrl, ctrl_word(prbs_pkg::mode_align, 2'b00, 1'b0, sel));
        repeat (40) @(posedge clk);
        host_write(prbs_pkg::addr_ctrl, ctrl_word(prbs_pkg::mode_test, 2'b00, 1'b0, sel));
        snapshot();
        expect_deltas(200, 64'd0, 64'(200 * ones(sel)));

        // injections on selected lanes, spaced past the history length
        for (int r = 0; r < 2; r++) begin
            mask = 16'($random(seed)) & sel;
            if (mask == 16'd0) begin
                mask = sel & (~sel + 16'd1);
            end
            host_write(prbs_pkg::addr_inject, {16'd0, mask});
            snapshot();
            expect_deltas(40, 64'(3 * ones(mask & sel)), 64'(40 * ones(sel)));
            expect_frame(1'b1);
        end

        // inject only on deselected lanes and always on lane 15
        sel = (16'($random(seed)) & 16'h7fff) | 16'h0001;
        host_write(prbs_pkg::addr_ctrl, ctrl_word(prbs_pkg::mode_test, 2'b00, 1'b0, sel));
        mask = (~sel & 16'($random(seed))) | 16'h8000;
        host_write(prbs_pkg::addr_inject, {16'd0, mask});
        snapshot();
        expect_deltas(40, 64'd0, 64'(40 * ones(sel)));
        expect_frame(1'b1);

        // freeze holds across an injection
        host_write(prbs_pkg::addr_ctrl, ctrl_word(prbs_pkg::mode_freeze, 2'b00, 1'b0, sel));
        host_write(prbs_pkg::addr_inject, {16'd0, sel});
        snapshot();
        expect_deltas(40, 64'd0, 64'd0);
        host_write(prbs_pkg::addr_ctrl, ctrl_word(prbs_pkg::mode_test, 2'b00, 1'b0, sel));
        snapshot();
        expect_deltas(50, 64'd0, 64'(50 * ones(sel)));

        // inverted line, inverted receive
        host_write(prbs_pkg::addr_ctrl, ctrl_word(prbs_pkg::mode_align, 2'b01, 1'b1, sel));
        repeat (40) @(posedge clk);
        host_write(prbs_pkg::addr_ctrl, ctrl_word(prbs_pkg::mode_test, 2'b01, 1'b1, sel));
        snapshot();
        expect_deltas(100, 64'd0, 64'(100 * ones(sel)));

        // inverted err on a clean stream counts every bit
        host_write(prbs_pkg::addr_ctrl, ctrl_word(prbs_pkg::mode_align, 2'b10, 1'b0, sel));
        repeat (40) @(posedge clk);
        host_write(prbs_pkg::addr_ctrl, ctrl_word(prbs_pkg::mode_test, 2'b10, 1'b0, sel));
        snapshot();
        expect_deltas(100, 64'(100 * ones(sel)), 64'(100 * ones(sel)));

        // reset mode clears on the next edge
        host_write(prbs_pkg::addr_ctrl, ctrl_word(prbs_pkg::mode_reset, 2'b00, 1'b0, sel));
        @(posedge clk);
        @(negedge clk);
        compare("err_bits", 64'd0, err_bits);
        compare("total_bits", 64'd0, total_bits);
        // a couple more edges so the bound clear checks complete
        repeat (2) @(posedge clk);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* prbs_loopback_top.f */
design/prbs_pkg.sv
design/prbs_ctrl_regs.sv
design/prbs_generator.sv
design/prbs_checker_core.sv
design/prbs_checker.sv
design/prbs_loopback_top.sv
dv/prbs_clk_gen.sv
dv/prbs_checker_checker.sv
dv/prbs_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the PRBS loopback testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module prbs_tb \
    -f prbs_loopback_top.f \
    -o Vprbs_tb

# a failing bound assertion stops the simulation with a nonzero status
./obj_dir/Vprbs_tb > sim.log 2>&1 || {
    cat sim.log
    echo "simulation exited with an error"
    exit 1
}

cat sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi

if grep -q "%Error" sim.log; then
    exit 1
fi

exit 0
